//--- tb.f
+incdir+logic
logic/lookup_pkg.sv
logic/key_tcam.sv
logic/action_ram.sv
logic/lookup_ctrl.sv
logic/ctrl_parser.sv
logic/lookup_engine.sv
tests/tb_clock.sv
tests/tb_lookup_engine.sv

//--- run.sh
#!/bin/sh
# build and run the lookup engine testbench, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_lookup_engine \
    && ./obj_dir/Vtb_lookup_engine > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^TESTS PASSED$" sim.log \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }

//--- tests/tb_lookup_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "lookup_cfg.svh"

module tb_lookup_engine;
    import lookup_pkg::*;

    localparam int STAGE_ID  = 2;
    localparam int LOOKUP_ID = 2;
    // 20 lookups plus 14 control packets
    localparam int NUM_TESTS = 34;
    localparam int LIMIT     = NUM_TESTS * 40 + 200;

    wire                        clk;
    wire                        rst_n;
    logic                       key_valid;
    lookup_req_t                req;
    logic                       action_valid;
    lookup_resp_t               resp;
    ctrl_beat_t                 c_in;
    ctrl_beat_t                 c_out;

    // model of both tables
    bit                         cam_vld [`LE_DEPTH];
    logic [`LE_KEY_W-1:0]       cam_key [`LE_DEPTH];
    logic [`LE_VLAN_NIB_W-1:0]  cam_nib [`LE_DEPTH];
    logic [`LE_ACT_W-1:0]       act_mem [`LE_DEPTH];

    logic [`LE_KEY_W-1:0]       ent_key [8];
    logic [`LE_VLAN_NIB_W-1:0]  ent_nib [8];
    logic [`LE_CDATA_W-1:0]     pkt_words [$];
    lookup_resp_t               resp_q [$];
    int                         resp_due_q [$];
    ctrl_beat_t                 fwd_q [$];
    int                         fwd_due_q [$];
    lookup_resp_t               exp_resp;
    int                         resp_due;
    ctrl_beat_t                 exp_beat;
    int                         beat_due;
    int                         cycle_cnt;
    logic [23:0]                lfsr_state;
    int                         resp_count;
    int                         resp_errors;
    int                         fwd_errors;
    int                         other_errors;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lookup_engine #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .req          (req),
        .action_valid (action_valid),
        .resp         (resp),
        .c_in         (c_in),
        .c_out        (c_out)
    );

    // rising edges since time zero
    always @(posedge clk) begin
        cycle_cnt++;
    end

    // x^24 + x^23 + x^22 + x^17 + 1
    function automatic logic [23:0] lfsr_next(input logic [23:0] s);
        return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
    endfunction

    task automatic take_bits(input int n, output logic [95:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[94:0], lfsr_state[0]};
        end
    endtask

    // lowest matching address wins
    function automatic lookup_resp_t expected_resp(input logic [`LE_KEY_W-1:0] key,
            input logic [`LE_KEY_W-1:0] mask, input logic [`LE_PHV_W-1:0] phv,
            output bit hit);
        lookup_resp_t r;
        logic [`LE_VLAN_NIB_W-1:0] nib;
        bit nib_care;
        bit found;
        nib = phv[`LE_VLAN_LSB +: `LE_VLAN_NIB_W];
        nib_care = (STAGE_ID != `LE_LAST_STAGE);
        found = 1'b0;
        r.action = `LE_ACT_W'(`LE_DEFAULT_ACT);
        r.phv = phv;
        for (int i = 0; i < `LE_DEPTH; i++) begin
            if (!found && cam_vld[i] && (((cam_key[i] ^ key) & ~mask) == '0) &&
                    (!nib_care || cam_nib[i] == nib)) begin
                found = 1'b1;
                r.action = act_mem[i];
            end
        end
        hit = found;
        return r;
    endfunction

    function automatic logic [63:0] make_header(input logic [15:0] flag, input int stage,
            input int lid, input logic [3:0] kind, input int idx);
        ctrl_header_t h;
        h = '{flag: flag, stage_id: 5'(stage), lookup_id: 3'(lid), kind: kind,
              index: 8'(idx), pad: '0};
        return h;
    endfunction

    task automatic make_phv(input logic [`LE_VLAN_NIB_W-1:0] nib, output logic [63:0] phv);
        logic [95:0] bits;
        take_bits(64, bits);
        phv = bits[63:0];
        phv[`LE_VLAN_LSB +: `LE_VLAN_NIB_W] = nib;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // bubbles go in front of every odd word
    task automatic send_packet(input bit bubbles, input bit forwarded);
        ctrl_beat_t beat;
        for (int i = 0; i < pkt_words.size(); i++) begin
            if (bubbles && i[0]) begin
                c_in = '0;
                idle_cycles(1);
            end
            beat = '{data: pkt_words[i], last: (i == pkt_words.size() - 1), valid: 1'b1};
            if (forwarded) begin
                fwd_q.push_back(beat);
                // sampled at the next edge, out one cycle later
                fwd_due_q.push_back(cycle_cnt + 1);
            end
            c_in = beat;
            idle_cycles(1);
        end
        c_in = '0;
    endtask

    task automatic program_cam(input int idx, input int first, input int n);
        logic [95:0] junk;
        int a;
        pkt_words = {make_header(`LE_CTRL_FLAG, STAGE_ID, LOOKUP_ID, `LE_KIND_CAM, idx)};
        for (int k = 0; k < n; k++) begin
            take_bits(36, junk);
            pkt_words.push_back({junk[35:0], ent_nib[first + k], ent_key[first + k]});
        end
        send_packet(1'b0, 1'b0);
        for (int k = 0; k < n; k++) begin
            a = (idx + k) % `LE_DEPTH;
            cam_vld[a] = 1'b1;
            cam_key[a] = ent_key[first + k];
            cam_nib[a] = ent_nib[first + k];
        end
        idle_cycles(3);
    endtask

    task automatic program_action(input int idx, input logic [95:0] act, input int extra);
        logic [95:0] junk;
        take_bits(32, junk);
        pkt_words = {make_header(`LE_CTRL_FLAG, STAGE_ID, LOOKUP_ID, 4'h1, idx)};
        pkt_words.push_back(act[95:32]);
        pkt_words.push_back({act[31:0], junk[31:0]});
        repeat (extra) begin
            take_bits(64, junk);
            pkt_words.push_back(junk[63:0]);
        end
        send_packet(1'b0, 1'b0);
        act_mem[idx] = act;
        idle_cycles(3);
    endtask

    task automatic send_foreign(input logic [15:0] flag, input int stage, input int lid,
            input int n, input bit bubbles);
        logic [95:0] bits;
        pkt_words = {make_header(flag, stage, lid, 4'h1, 2)};
        for (int k = 1; k < n; k++) begin
            take_bits(64, bits);
            pkt_words.push_back(bits[63:0]);
        end
        send_packet(bubbles, 1'b1);
    endtask

    task automatic run_lookup(input logic [`LE_KEY_W-1:0] key,
            input logic [`LE_KEY_W-1:0] mask, input logic [`LE_PHV_W-1:0] phv);
        lookup_resp_t want;
        bit hit;
        int start;
        start = resp_count;
        want = expected_resp(key, mask, phv, hit);
        resp_q.push_back(want);
        // key sampled at the next edge, pulse two cycles later on a miss, three on a hit
        resp_due_q.push_back(cycle_cnt + 1 + (hit ? 3 : 2));
        req = '{key: key, mask: mask, phv: phv};
        key_valid = 1'b1;
        idle_cycles(1);
        key_valid = 1'b0;
        for (int i = 0; i < 8 && resp_count == start; i++) begin
            idle_cycles(1);
        end
        assert (resp_count != start) else begin
            $display("no action_valid pulse within 8 cycles of key %h", key);
            other_errors++;
            void'(resp_q.pop_back());
            void'(resp_due_q.pop_back());
        end
    endtask

    always @(negedge clk) begin
        if (action_valid) begin
            resp_count++;
            assert (resp_q.size() != 0) else begin
                $display("action_valid pulsed with no lookup pending at %0t", $time);
                other_errors++;
            end
            if (resp_q.size() != 0) begin
                exp_resp = resp_q.pop_front();
                resp_due = resp_due_q.pop_front();
                assert (cycle_cnt == resp_due) else begin
                    $display("CHECK FAILED action_valid cycle expected %h got %h",
                             resp_due, cycle_cnt);
                    resp_errors++;
                end
                assert (resp.action == exp_resp.action) else begin
                    $display("CHECK FAILED resp.action expected %h got %h",
                             exp_resp.action, resp.action);
                    resp_errors++;
                end
                assert (resp.phv == exp_resp.phv) else begin
                    $display("CHECK FAILED resp.phv expected %h got %h",
                             exp_resp.phv, resp.phv);
                    resp_errors++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (c_out.valid) begin
            assert (fwd_q.size() != 0) else begin
                $display("c_out carried a beat that was not expected, data %h", c_out.data);
                fwd_errors++;
            end
            if (fwd_q.size() != 0) begin
                exp_beat = fwd_q.pop_front();
                beat_due = fwd_due_q.pop_front();
                assert (cycle_cnt == beat_due) else begin
                    $display("CHECK FAILED c_out.valid cycle expected %h got %h",
                             beat_due, cycle_cnt);
                    fwd_errors++;
                end
                assert (c_out.data == exp_beat.data) else begin
                    $display("CHECK FAILED c_out.data expected %h got %h",
                             exp_beat.data, c_out.data);
                    fwd_errors++;
                end
                assert (c_out.last == exp_beat.last) else begin
                    $display("CHECK FAILED c_out.last expected %h got %h",
                             exp_beat.last, c_out.last);
                    fwd_errors++;
                end
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not complete", LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [95:0] bits;
        logic [63:0] phv;
        key_valid = 1'b0;
        req = '0;
        c_in = '0;
        cycle_cnt = 0;
        lfsr_state = 24'd41;
        for (int i = 0; i < `LE_DEPTH; i++) begin
            cam_vld[i] = 1'b0;
            act_mem[i] = '0;
        end
        wait (rst_n === 1'b1);
        idle_cycles(1);

        // quiet outputs and then a miss on the empty tables
        repeat (4) begin
            assert (action_valid === 1'b0 && c_out.valid === 1'b0) else begin
                $display("action_valid or c_out.valid high after reset with no input");
                other_errors++;
            end
            idle_cycles(1);
        end
        take_bits(64, bits);
        run_lookup(bits[23:0], 24'h0, bits[63:0]);

        // four entries at 3..6 from one packet and their actions
        for (int i = 0; i < 4; i++) begin
            take_bits(28, bits);
            ent_key[i] = bits[23:0];
            ent_nib[i] = bits[27:24];
        end
        program_cam(3, 0, 4);
        for (int i = 0; i < 4; i++) begin
            take_bits(96, bits);
            program_action(3 + i, bits, 0);
        end
        for (int i = 0; i < 4; i++) begin
            make_phv(ent_nib[i], phv);
            run_lookup(ent_key[i], 24'h0, phv);
        end
        repeat (8) begin
            take_bits(24, bits);
            make_phv(bits[3:0], phv);
            run_lookup(bits[23:0], 24'h0, phv);
        end

        // index wraps from 15 to 0 and two entries overlap under the mask
        take_bits(28, bits);
        ent_key[4] = bits[23:0];
        ent_nib[4] = bits[27:24];
        ent_key[5] = ent_key[4] ^ 24'h0000ff;
        ent_nib[5] = ent_nib[4];
        program_cam(15, 4, 2);
        take_bits(96, bits);
        program_action(15, bits, 0);
        take_bits(96, bits);
        program_action(0, bits, 0);
        make_phv(ent_nib[4], phv);
        run_lookup(ent_key[4], 24'h0, phv);
        run_lookup(ent_key[5], 24'h0, phv);
        run_lookup(ent_key[4] ^ 24'h00005a, 24'h0000ff, phv);
        run_lookup(24'h0, 24'hffffff, phv);
        make_phv(ent_nib[2], phv);
        run_lookup(ent_key[2] ^ 24'h0f0000, 24'h0f0000, phv);

        // right key with a wrong vlan nibble
        make_phv(ent_nib[0] ^ 4'h8, phv);
        run_lookup(ent_key[0], 24'h0, phv);

        // foreign packets back to back with one own packet in between
        send_foreign(16'hf2f0, STAGE_ID, LOOKUP_ID, 3, 1'b0);
        take_bits(96, bits);
        program_action(9, bits, 2);
        send_foreign(`LE_CTRL_FLAG, 3, LOOKUP_ID, 4, 1'b1);
        send_foreign(`LE_CTRL_FLAG, STAGE_ID, 1, 1, 1'b0);
        send_foreign(`LE_CTRL_FLAG, STAGE_ID, 3, 5, 1'b1);
        idle_cycles(4);

        // new action at address 4
        take_bits(96, bits);
        program_action(4, bits, 0);
        make_phv(ent_nib[1], phv);
        run_lookup(ent_key[1], 24'h0, phv);

        idle_cycles(5);
        assert (fwd_q.size() == 0) else begin
            $display("%0d forwarded beats never appeared on c_out", fwd_q.size());
            other_errors++;
        end
        $display("errors: response %0d, c_out %0d, other %0d",
                 resp_errors, fwd_errors, other_errors);
        if (resp_errors + fwd_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/lookup_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "lookup_cfg.svh"

module lookup_engine #(
    parameter int unsigned STAGE_ID  = 0,
    parameter int unsigned LOOKUP_ID = 0
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          key_valid,
    input  lookup_pkg::lookup_req_t      req,
    output logic                         action_valid,
    output lookup_pkg::lookup_resp_t     resp,
    input  lookup_pkg::ctrl_beat_t       c_in,
    output lookup_pkg::ctrl_beat_t       c_out
);
    import lookup_pkg::*;

    // last stage matches on the key alone
    localparam bit VLAN_CARE = (STAGE_ID != `LE_LAST_STAGE);

    logic [`LE_VLAN_NIB_W-1:0]  vlan_nib;
    cam_entry_t                 search_key;
    logic [`LE_KEY_W-1:0]       search_mask;
    logic                       match;
    act_addr_t                  match_addr;
    logic [`LE_ACT_W-1:0]       rd_action;

    logic                       cam_we;
    act_addr_t                  cam_addr;
    cam_entry_t                 cam_wdata;
    logic                       act_we;
    act_addr_t                  act_addr;
    logic [`LE_ACT_W-1:0]       act_wdata;

    assign vlan_nib = req.phv[`LE_VLAN_LSB +: `LE_VLAN_NIB_W];

    lookup_ctrl u_lookup_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .req          (req),
        .vlan_nib     (vlan_nib),
        .match        (match),
        .rd_action    (rd_action),
        .search_key   (search_key),
        .search_mask  (search_mask),
        .action_valid (action_valid),
        .resp         (resp)
    );

    key_tcam #(
        .VLAN_CARE (VLAN_CARE)
    ) u_key_tcam (
        .clk         (clk),
        .rst_n       (rst_n),
        .search_key  (search_key),
        .search_mask (search_mask),
        .we          (cam_we),
        .wr_addr     (cam_addr),
        .wr_data     (cam_wdata),
        .match       (match),
        .match_addr  (match_addr)
    );

    // read address comes straight from the cam result
    action_ram u_action_ram (
        .clk       (clk),
        .we        (act_we),
        .wr_addr   (act_addr),
        .wr_data   (act_wdata),
        .rd_addr   (match_addr),
        .rd_action (rd_action)
    );

    ctrl_parser #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) u_ctrl_parser (
        .clk       (clk),
        .rst_n     (rst_n),
        .c_in      (c_in),
        .c_out     (c_out),
        .cam_we    (cam_we),
        .cam_addr  (cam_addr),
        .cam_wdata (cam_wdata),
        .act_we    (act_we),
        .act_addr  (act_addr),
        .act_wdata (act_wdata)
    );

endmodule

`default_nettype wire

//--- logic/ctrl_parser.sv
`timescale 1ns/100ps
`default_nettype none

`include "lookup_cfg.svh"

module ctrl_parser #(
    parameter int unsigned STAGE_ID  = 0,
    parameter int unsigned LOOKUP_ID = 0
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  lookup_pkg::ctrl_beat_t     c_in,
    output lookup_pkg::ctrl_beat_t     c_out,
    output logic                       cam_we,
    output lookup_pkg::act_addr_t      cam_addr,
    output lookup_pkg::cam_entry_t     cam_wdata,
    output logic                       act_we,
    output lookup_pkg::act_addr_t      act_addr,
    output logic [`LE_ACT_W-1:0]       act_wdata
);
    import lookup_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CAM,
        ST_ACT_HI,
        ST_ACT_LO,
        ST_DRAIN,
        ST_FWD
    } state_t;

    // bits taken from the top of word 2
    localparam int ACT_LO_W = `LE_ACT_W - `LE_CDATA_W;

    state_t        state;
    ctrl_header_t  hdr;
    logic          own;
    logic          kind_cam;
    act_addr_t     cam_ptr;

    assign hdr = ctrl_header_t'(c_in.data);

    // addressed to this stage and this table
    assign own = (hdr.flag == `LE_CTRL_FLAG) &&
                 (hdr.stage_id == 5'(STAGE_ID)) &&
                 (hdr.lookup_id == 3'(LOOKUP_ID));
    assign kind_cam = (hdr.kind == `LE_KIND_CAM);

    // table addresses and write data
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (c_in.valid) begin
                    cam_ptr  <= hdr.index[`LE_ADDR_W-1:0];
                    act_addr <= hdr.index[`LE_ADDR_W-1:0];
                end
            end
            // one entry per word, index wraps at the table depth
            ST_CAM: begin
                if (c_in.valid) begin
                    cam_addr  <= cam_ptr;
                    cam_ptr   <= cam_ptr + 1'b1;
                    cam_wdata <= cam_entry_t'(c_in.data[$bits(cam_entry_t)-1:0]);
                end
            end
            ST_ACT_HI: begin
                if (c_in.valid) begin
                    act_wdata[`LE_ACT_W-1 -: `LE_CDATA_W] <= c_in.data;
                end
            end
            ST_ACT_LO: begin
                if (c_in.valid) begin
                    act_wdata[ACT_LO_W-1:0] <= c_in.data[`LE_CDATA_W-1 -: ACT_LO_W];
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            cam_we <= 1'b0;
            act_we <= 1'b0;
            c_out  <= '0;
        end else begin
            cam_we      <= 1'b0;
            act_we      <= 1'b0;
            c_out.valid <= 1'b0;
            c_out.last  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (c_in.valid) begin
                        if (own) begin
                            if (!c_in.last) begin
                                state <= kind_cam ? ST_CAM : ST_ACT_HI;
                            end
                        end else begin
                            // foreign header goes straight out
                            c_out <= c_in;
                            if (!c_in.last) begin
                                state <= ST_FWD;
                            end
                        end
                    end
                end
                ST_CAM: begin
                    if (c_in.valid) begin
                        cam_we <= 1'b1;
                        if (c_in.last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                // a packet ending here leaves the action table alone
                ST_ACT_HI: begin
                    if (c_in.valid) begin
                        state <= c_in.last ? ST_IDLE : ST_ACT_LO;
                    end
                end
                ST_ACT_LO: begin
                    if (c_in.valid) begin
                        act_we <= 1'b1;
                        state  <= c_in.last ? ST_IDLE : ST_DRAIN;
                    end
                end
                // extra words of an action packet
                ST_DRAIN: begin
                    if (c_in.valid && c_in.last) begin
                        state <= ST_IDLE;
                    end
                end
                ST_FWD: begin
                    if (c_in.valid) begin
                        c_out <= c_in;
                        if (c_in.last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/lookup_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "lookup_cfg.svh"

module lookup_ctrl (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          key_valid,
    input  lookup_pkg::lookup_req_t      req,
    input  wire [`LE_VLAN_NIB_W-1:0]     vlan_nib,
    input  wire                          match,
    input  wire [`LE_ACT_W-1:0]          rd_action,
    output lookup_pkg::cam_entry_t       search_key,
    output logic [`LE_KEY_W-1:0]         search_mask,
    output logic                         action_valid,
    output lookup_pkg::lookup_resp_t     resp
);
    import lookup_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_MATCH,
        ST_WAIT_RAM,
        ST_TRANSMIT
    } state_t;

    localparam logic [`LE_ACT_W-1:0] DEFAULT_ACT = `LE_DEFAULT_ACT;

    state_t                     state;
    lookup_req_t                req_q;
    logic [`LE_VLAN_NIB_W-1:0]  nib_q;
    logic                       capture;
    logic                       issue_miss;
    logic                       issue_hit;

    // only one lookup in flight, keys are dropped while busy
    assign capture    = (state == ST_IDLE) && key_valid;
    // match result is readable while the ram read is running
    assign issue_miss = (state == ST_WAIT_RAM) && !match;
    assign issue_hit  = (state == ST_TRANSMIT);

    assign search_key  = '{vlan_nib: nib_q, key: req_q.key};
    assign search_mask = req_q.mask;

    always_ff @(posedge clk) begin
        if (capture) begin
            req_q <= req;
            nib_q <= vlan_nib;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_miss) begin
            resp <= '{action: DEFAULT_ACT, phv: req_q.phv};
        end else if (issue_hit) begin
            resp <= '{action: rd_action, phv: req_q.phv};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            action_valid <= 1'b0;
        end else begin
            action_valid <= issue_miss || issue_hit;
            case (state)
                ST_IDLE: begin
                    if (key_valid) begin
                        state <= ST_WAIT_MATCH;
                    end
                end
                // cam compares the captured key
                ST_WAIT_MATCH: begin
                    state <= ST_WAIT_RAM;
                end
                ST_WAIT_RAM: begin
                    state <= match ? ST_TRANSMIT : ST_IDLE;
                end
                ST_TRANSMIT: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/action_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "lookup_cfg.svh"

module action_ram (
    input  wire                       clk,
    input  wire                       we,
    input  lookup_pkg::act_addr_t     wr_addr,
    input  wire [`LE_ACT_W-1:0]       wr_data,
    input  lookup_pkg::act_addr_t     rd_addr,
    output logic [`LE_ACT_W-1:0]      rd_action
);

    logic [`LE_ACT_W-1:0] mem [`LE_DEPTH];

    // unwritten entries read as zero
    initial begin
        for (int i = 0; i < `LE_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_action <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- logic/key_tcam.sv
`timescale 1ns/100ps
`default_nettype none

`include "lookup_cfg.svh"

module key_tcam #(
    parameter bit VLAN_CARE = 1'b1
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  lookup_pkg::cam_entry_t    search_key,
    input  wire [`LE_KEY_W-1:0]       search_mask,
    input  wire                       we,
    input  lookup_pkg::act_addr_t     wr_addr,
    input  lookup_pkg::cam_entry_t    wr_data,
    output logic                      match,
    output lookup_pkg::act_addr_t     match_addr
);
    import lookup_pkg::*;

    localparam int ENTRY_W = $bits(cam_entry_t);

    cam_entry_t              entries [`LE_DEPTH];
    logic [`LE_DEPTH-1:0]    entry_vld;
    logic [`LE_DEPTH-1:0]    hit_vec;
    logic [ENTRY_W-1:0]      care_bits;
    act_addr_t               hit_addr;

    // nibble compared unless this is the last stage
    assign care_bits = {{`LE_VLAN_NIB_W{VLAN_CARE}}, ~search_mask};

    always_ff @(posedge clk) begin
        if (we) begin
            entries[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        for (int i = 0; i < `LE_DEPTH; i++) begin
            hit_vec[i] = entry_vld[i] &&
                (((entries[i] ^ search_key) & care_bits) == '0);
        end
    end

    // lowest matching address wins
    always_comb begin
        hit_addr = '0;
        for (int i = `LE_DEPTH - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_addr = act_addr_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_vld  <= '0;
            match      <= 1'b0;
            match_addr <= '0;
        end else begin
            if (we) begin
                entry_vld[wr_addr] <= 1'b1;
            end
            match      <= |hit_vec;
            match_addr <= hit_addr;
        end
    end

endmodule

`default_nettype wire

//--- logic/lookup_pkg.sv
`default_nettype none

`include "lookup_cfg.svh"

package lookup_pkg;

    // one word of the control stream
    typedef struct packed {
        logic [`LE_CDATA_W-1:0] data;
        logic                   last;
        logic                   valid;
    } ctrl_beat_t;

    // first word of a control packet
    typedef struct packed {
        logic [15:0] flag;
        logic [4:0]  stage_id;
        logic [2:0]  lookup_id;
        logic [3:0]  kind;
        logic [7:0]  index;
        logic [27:0] pad;
    } ctrl_header_t;

    // stored cam word, sits in the low bits of a cam data word
    typedef struct packed {
        logic [`LE_VLAN_NIB_W-1:0] vlan_nib;
        logic [`LE_KEY_W-1:0]      key;
    } cam_entry_t;

    // mask bit set means don't care
    typedef struct packed {
        logic [`LE_KEY_W-1:0] key;
        logic [`LE_KEY_W-1:0] mask;
        logic [`LE_PHV_W-1:0] phv;
    } lookup_req_t;

    typedef struct packed {
        logic [`LE_ACT_W-1:0] action;
        logic [`LE_PHV_W-1:0] phv;
    } lookup_resp_t;

    typedef logic [`LE_ADDR_W-1:0] act_addr_t;

endpackage

`default_nettype wire

//--- logic/lookup_cfg.svh
`ifndef LOOKUP_CFG_SVH
`define LOOKUP_CFG_SVH

// key and mask width
`define LE_KEY_W        24
// vlan nibble appended to the key
`define LE_VLAN_NIB_W   4
`define LE_PHV_W        64
// position of the compared nibble inside the phv
`define LE_VLAN_LSB     8
`define LE_ACT_W        96

// table geometry, shared by cam and action ram
`define LE_DEPTH        16
`define LE_ADDR_W       4

// control stream word
`define LE_CDATA_W      64
`define LE_CTRL_FLAG    16'hf2f1
// kind code of a cam write packet, anything else writes an action
`define LE_KIND_CAM     4'h0

// action returned on a miss
`define LE_DEFAULT_ACT  'h3f
// this stage compares the key only, no vlan nibble
`define LE_LAST_STAGE   4

`endif
